// ==== verilog.f ====
+incdir+.
smc_pkg.sv
smc_apb_regs.sv
smc_ahb_slave.sv
smc_lane_gen.sv
smc_ctrl.sv
smc_top.sv
smc_mem_model.sv
tb_smc.sv

// ==== tb_smc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "smc_defines.svh"

module tb_smc import smc_pkg::*; ();

  localparam int          CLK_PERIOD   = 4;
  localparam int unsigned SEED         = 32'hbc8a;
  localparam int          WINDOW_BYTES = `SMC_MEM_WORDS * 4;
  localparam int          MAX_WAIT     = (1 << `SMC_WAIT_W) - 1;
  localparam logic [2:0]  SIZE_WORD    = 3'b010;
  localparam int N_WORD      = 16;  // Word writes then as many reads
  localparam int N_LANE      = 24;  // Sub-word write plus word read
  localparam int N_ROUND     = 4;   // Wait-state settings
  localparam int N_PER_ROUND = 8;
  localparam int N_ERR       = 6;   // Must not exceed N_WORD
  localparam int N_PIPE      = 24;
  localparam int N_XFER      = 2*N_WORD + 2*N_LANE + N_ROUND*N_PER_ROUND + 2*N_ERR + N_PIPE;
  localparam int MAX_ACCESS  = MAX_WAIT + 5;  // Longest strobe plus setup, done, idle and margin
  localparam int WATCHDOG_NS = (N_XFER * MAX_ACCESS + N_ROUND * 30 + 100) * CLK_PERIOD;

  typedef struct packed {
    logic        write;
    logic [2:0]  size;
    logic [31:0] addr;
    logic [31:0] wdata;
  } op_t;

  typedef struct packed {
    logic        rd;     // OKAY read, data checked
    logic        err;
    logic        wr;
    logic [3:0]  n_be;   // Active low lanes
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] data;
    logic [7:0]  low;    // hready low cycles in the data phase
  } exp_t;

  logic        hclk, rst_n, psel, penable, pwrite, hsel, hwrite, hready;
  logic [4:0]  paddr;
  logic [31:0] pwdata, prdata, haddr, hwdata, smc_hrdata, smc_addr, smc_data, data_smc;
  logic [1:0]  htrans, smc_hresp;
  logic [2:0]  hsize;
  logic [3:0]  smc_n_be, smc_n_we;
  logic        smc_hready, smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;

  logic [31:0] shadow [0:`SMC_MEM_WORDS-1];  // Expected memory contents
  logic [31:0] picked [0:N_WORD-1];
  op_t         op_q[$];
  exp_t        exp_q[$];
  exp_t        cur;                            // Transfer now in its data phase
  logic        active;
  int          low_cnt;
  int unsigned cur_rd_wait, cur_wr_wait;

  assign hready = smc_hready;  // Single slave so ready loops back

  smc_top dut (.*);

  smc_mem_model u_mem (
    .n_cs  (smc_n_cs),
    .n_rd  (smc_n_rd),
    .n_we  (smc_n_we),
    .addr  (smc_addr),
    .wdata (smc_data),
    .rdata (data_smc)
  );

  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  // --------------------------------------------------
  // Checking helpers and reference model
  // --------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                        $time, name, got, exp));
  endtask

  // Byte lanes of a transfer from size and low address bits
  function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] lo);
    logic [3:0] m;
    for (int b = 0; b < 4; b++) begin
      case (size)
        HSIZE_BYTE: m[b] = (b == lo);        // Just the addressed byte
        HSIZE_HALF: m[b] = (b / 2 == lo[1]);  // Pair chosen by bit 1
        default:    m[b] = 1'b1;
      endcase
    end
    return m;
  endfunction

  // New word after a write, only enabled lanes change
  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] lanes);
    logic [31:0] word;
    for (int b = 0; b < 4; b++) begin
      word[8*b +: 8] = lanes[b] ? wdata[8*b +: 8] : old[8*b +: 8];
    end
    return word;
  endfunction

  function automatic logic [31:0] pick_addr(input logic [2:0] size, input int words);
    logic [31:0] a;
    a = $urandom_range(0, words * 4 - 1);
    if (size == HSIZE_HALF) a[0] = 1'b0;
    else if (size != HSIZE_BYTE) a[1:0] = 2'b00;
    return a;
  endfunction

  // Expected outcome worked out at queue time as transfers finish in order
  task automatic queue_xfer(input logic write, input logic [2:0] size,
                            input logic [31:0] addr, input logic [31:0] wdata);
    exp_t        e;
    int unsigned w;
    logic [3:0]  lanes;
    w       = (addr >> 2) % `SMC_MEM_WORDS;
    lanes   = lane_mask(size, addr[1:0]);
    e.err   = (addr >= WINDOW_BYTES);
    e.rd    = !write && !e.err;
    e.wr    = write;
    e.n_be  = ~lanes;
    e.addr  = addr;
    e.wdata = wdata;
    e.data  = '0;
    e.low   = 8'd1;  // ERR1 only
    if (!e.err && write) begin
      shadow[w] = merge_lanes(shadow[w], wdata, lanes);
      e.low     = 8'(cur_wr_wait + 2);
    end else if (!e.err) begin
      e.data = shadow[w];
      e.low  = 8'(cur_rd_wait + 2);
    end
    op_q.push_back({write, size, addr, wdata});
    exp_q.push_back(e);
  endtask

  // Memory pins for the transfer in flight
  task automatic expect_pins(input logic sel, input logic strobe);
    logic rd_lo;
    logic wr_lo;
    rd_lo = strobe && !cur.wr;
    wr_lo = strobe && cur.wr;
    check_value("smc_n_cs", smc_n_cs, !sel);
    check_value("smc_n_rd", smc_n_rd, !rd_lo);
    check_value("smc_n_wr", smc_n_wr, !wr_lo);
    check_value("smc_n_we", smc_n_we, wr_lo ? cur.n_be : 4'hf);  // Enabled lanes only
    check_value("smc_n_ext_oe", smc_n_ext_oe, !wr_lo);
    if (sel) check_value("smc_addr", smc_addr, {cur.addr[31:2], 2'b00});
    if (wr_lo) check_value("smc_data", smc_data, cur.wdata);
  endtask

  // --------------------------------------------------
  // Bus drivers
  // --------------------------------------------------
  task automatic wait_ready();
    @(negedge hclk);
    while (smc_hready !== 1'b1) @(negedge hclk);
    @(posedge hclk);  // Edge where the DUT sees ready
  endtask

  task automatic run_xfers(input logic pipelined);
    op_t op;
    @(posedge hclk);
    while (op_q.size() > 0) begin
      op = op_q.pop_front();
      hsel   <= 1'b1;
      htrans <= HTRANS_NONSEQ;
      hwrite <= op.write;
      hsize  <= op.size;
      haddr  <= op.addr;
      wait_ready();              // Address phase accepted
      hwdata <= op.wdata;        // Held through the data phase
      if (!pipelined || op_q.size() == 0) begin
        hsel   <= 1'b0;
        htrans <= HTRANS_IDLE;
        wait_ready();            // Data phase over
      end
    end
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(posedge hclk);
    psel    <= 1'b1;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge hclk);
    penable <= 1'b1;
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_expect(input logic [4:0] addr, input logic [31:0] exp, input string name);
    @(posedge hclk);
    psel    <= 1'b1;
    paddr   <= addr;
    @(posedge hclk);
    penable <= 1'b1;
    @(negedge hclk);
    check_value(name, prdata, exp);  // Access phase
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic set_waits(input int unsigned rdw, input int unsigned wrw);
    apb_write(REG_RD_WAIT, ($urandom & 32'hffff_fff0) | rdw);  // Junk above the field
    apb_write(REG_WR_WAIT, ($urandom & 32'hffff_fff0) | wrw);
    cur_rd_wait = rdw;
    cur_wr_wait = wrw;
    apb_expect(REG_RD_WAIT, rdw, "prdata rd_wait");
    apb_expect(REG_WR_WAIT, wrw, "prdata wr_wait");
  endtask

  // --------------------------------------------------
  // Response monitor
  // --------------------------------------------------
  always @(negedge hclk) begin
    if (rst_n) begin
      if (active) begin
        check_value("smc_busy", smc_busy, 1);
        check_value("smc_hresp", smc_hresp, cur.err ? HRESP_ERROR : HRESP_OKAY);
        check_value("smc_n_be", smc_n_be, cur.n_be);
        if (smc_hready !== 1'b1) begin
          low_cnt++;
          expect_pins(!cur.err, !cur.err && low_cnt >= 2);  // No memory cycle on ERROR
        end else begin
          expect_pins(1'b0, 1'b0);  // DONE or ERR2
          check_value("hready low cycles", low_cnt, cur.low);
          if (cur.rd) check_value("smc_hrdata", smc_hrdata, cur.data);
          active = 1'b0;
        end
      end else begin
        check_value("smc_hready", smc_hready, 1);
        check_value("smc_hresp", smc_hresp, HRESP_OKAY);
        expect_pins(1'b0, 1'b0);
        check_value("smc_busy", smc_busy, 0);
      end
      if (hsel && htrans[1] && smc_hready) begin  // NONSEQ or SEQ taken
        if (exp_q.size() == 0) begin
          stop_run("Transfer accepted while no transfer was expected");
        end else begin
          cur     = exp_q.pop_front();
          active  = 1'b1;
          low_cnt = 0;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    stop_run($sformatf("Watchdog expired at %0t ns with the test still running", $time));
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] a;
    logic [2:0]  sz;
    int unsigned rdw;
    int unsigned wrw;
    void'($urandom(SEED));
    rst_n <= 1'b0;
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= '0;
    pwdata <= '0;
    hsel <= 1'b0;
    htrans <= HTRANS_IDLE;
    hwrite <= 1'b0;
    hsize <= SIZE_WORD;
    haddr <= '0;
    hwdata <= '0;
    active = 1'b0;
    low_cnt = 0;
    cur_rd_wait = `SMC_RD_WAIT_RST;
    cur_wr_wait = `SMC_WR_WAIT_RST;
    for (int i = 0; i < `SMC_MEM_WORDS; i++) begin
      u_mem.mem[i] = 32'hc35a_0000 ^ (i * 32'h0001_0001);  // Word index in both halves
      shadow[i]    = 32'hc35a_0000 ^ (i * 32'h0001_0001);
    end
    repeat (4) @(posedge hclk);
    rst_n <= 1'b1;

    // Idle outputs and register reset values
    @(negedge hclk);
    check_value("smc_n_rd", smc_n_rd, 1);
    check_value("smc_n_wr", smc_n_wr, 1);
    check_value("smc_n_we", smc_n_we, 4'hf);
    check_value("smc_n_ext_oe", smc_n_ext_oe, 1);
    apb_expect(REG_RD_WAIT, `SMC_RD_WAIT_RST, "prdata rd_wait");
    apb_expect(REG_WR_WAIT, `SMC_WR_WAIT_RST, "prdata wr_wait");
    apb_expect(REG_STATUS, 0, "prdata status");

    for (int i = 0; i < N_WORD; i++) begin
      picked[i] = pick_addr(SIZE_WORD, `SMC_MEM_WORDS);
      queue_xfer(1'b1, SIZE_WORD, picked[i], $urandom);
    end
    for (int i = 0; i < N_WORD; i++) queue_xfer(1'b0, SIZE_WORD, picked[i], 0);
    run_xfers(1'b0);

    // Byte and halfword writes, each checked by a word read
    for (int i = 0; i < N_LANE; i++) begin
      sz = $urandom_range(0, 1);
      a  = pick_addr(sz, `SMC_MEM_WORDS);
      queue_xfer(1'b1, sz, a, $urandom);
      queue_xfer(1'b0, SIZE_WORD, a & ~32'h3, 0);
    end
    run_xfers(1'b0);

    for (int r = 0; r < N_ROUND; r++) begin
      rdw = (r == 0) ? 0 : (r == N_ROUND - 1) ? MAX_WAIT : $urandom_range(0, MAX_WAIT);
      wrw = (r == 0) ? 0 : (r == N_ROUND - 1) ? MAX_WAIT : $urandom_range(0, MAX_WAIT);
      set_waits(rdw, wrw);
      for (int i = 0; i < N_PER_ROUND; i++) begin
        sz = $urandom_range(0, 2);
        queue_xfer($urandom_range(0, 1), sz, pick_addr(sz, `SMC_MEM_WORDS), $urandom);
      end
      run_xfers(r % 2);  // Spaced and back to back in turn
    end

    // Out of window accesses then reads of the aliased words
    for (int i = 0; i < N_ERR; i++) begin
      picked[i] = WINDOW_BYTES + ($urandom & 32'h00ff_fffc);
      queue_xfer(i % 2 == 0, SIZE_WORD, picked[i], $urandom);
    end
    for (int i = 0; i < N_ERR; i++) queue_xfer(1'b0, SIZE_WORD, picked[i] % WINDOW_BYTES, 0);
    run_xfers(1'b0);

    for (int i = 0; i < N_PIPE; i++) begin
      sz = $urandom_range(0, 2);
      a  = pick_addr(sz, 8);                                // Few words and many hazards
      if ($urandom_range(0, 7) == 0) a = a + WINDOW_BYTES;  // Occasional ERROR in the stream
      queue_xfer($urandom_range(0, 1), sz, a, $urandom);
    end
    run_xfers(1'b1);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== smc_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "smc_defines.svh"

// Asynchronous SRAM with byte writes, testbench only
module smc_mem_model (
  input  wire logic                   n_cs,
  input  wire logic                   n_rd,
  input  wire logic [3:0]             n_we,    // One write strobe per byte lane
  input  wire logic [`SMC_AW-1:0]     addr,
  input  wire logic [`SMC_DW-1:0]     wdata,
  output logic      [`SMC_DW-1:0]     rdata
);

  localparam int IW = $clog2(`SMC_MEM_WORDS);  // Word index width

  logic [`SMC_DW-1:0] mem [0:`SMC_MEM_WORDS-1];
  logic [IW-1:0]      idx;

  genvar lane;

  assign idx = addr[IW+1:2];  // Byte address to word

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------
  // Output only while selected and read strobe low
  assign rdata = (!n_cs && !n_rd) ? mem[idx] : 'x;

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------
  // Each lane latches at the end of its write pulse
  for (lane = 0; lane < 4; lane++) begin : g_lane
    always @(posedge n_we[lane]) begin
      if (!$isunknown(addr)) begin  // No write on the x to 1 edge at power up
        mem[idx][8*lane +: 8] <= wdata[8*lane +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== smc_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "smc_defines.svh"

// Static memory controller, AHB-lite in, SRAM bus out
module smc_top (
  input  wire logic                   hclk,
  input  wire logic                   rst_n,
  // APB configuration port, runs on hclk
  input  wire logic                   psel,
  input  wire logic                   penable,
  input  wire logic                   pwrite,
  input  wire logic [4:0]             paddr,
  input  wire logic [31:0]            pwdata,
  output logic      [31:0]            prdata,
  // AHB-lite slave
  input  wire logic [`SMC_AW-1:0]     haddr,
  input  wire logic [1:0]             htrans,
  input  wire logic                   hsel,
  input  wire logic                   hwrite,
  input  wire logic [2:0]             hsize,
  input  wire logic [`SMC_DW-1:0]     hwdata,
  input  wire logic                   hready,
  output logic      [`SMC_DW-1:0]     smc_hrdata,
  output logic                        smc_hready,
  output logic      [1:0]             smc_hresp,
  // External memory bus, strobes active low
  output logic      [`SMC_AW-1:0]     smc_addr,
  output logic      [`SMC_DW-1:0]     smc_data,
  input  wire logic [`SMC_DW-1:0]     data_smc,
  output logic      [3:0]             smc_n_be,
  output logic                        smc_n_cs,
  output logic      [3:0]             smc_n_we,
  output logic                        smc_n_wr,
  output logic                        smc_n_rd,
  output logic                        smc_n_ext_oe,
  output logic                        smc_busy
);

  logic                   start;
  logic                   out_of_range;
  logic                   write;
  logic [2:0]             size;
  logic [1:0]             addr_lo;
  logic [`SMC_AW-3:0]     word_addr;
  logic                   capture;
  logic                   done;
  logic                   err_state;
  logic [`SMC_WAIT_W-1:0] rd_wait;
  logic [`SMC_WAIT_W-1:0] wr_wait;

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------
  smc_apb_regs u_apb_regs (
    .hclk    (hclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .busy    (smc_busy),
    .prdata  (prdata),
    .rd_wait (rd_wait),
    .wr_wait (wr_wait)
  );

  smc_ahb_slave u_ahb_slave (
    .hclk         (hclk),
    .rst_n        (rst_n),
    .hsel         (hsel),
    .htrans       (htrans),
    .hwrite       (hwrite),
    .hsize        (hsize),
    .haddr        (haddr),
    .hready       (hready),
    .data_smc     (data_smc),
    .capture      (capture),
    .done         (done),
    .err_state    (err_state),
    .start        (start),
    .out_of_range (out_of_range),
    .write        (write),
    .size         (size),
    .addr_lo      (addr_lo),
    .word_addr    (word_addr),
    .smc_hrdata   (smc_hrdata),
    .smc_hready   (smc_hready),
    .smc_hresp    (smc_hresp)
  );

  smc_lane_gen u_lane_gen (
    .hclk      (hclk),
    .rst_n     (rst_n),
    .start     (start),
    .size      (size),
    .addr_lo   (addr_lo),
    .word_addr (word_addr),
    .hwdata    (hwdata),
    .smc_addr  (smc_addr),
    .smc_data  (smc_data),
    .n_be      (smc_n_be)  // Also feeds the write strobes
  );

  smc_ctrl u_ctrl (
    .hclk         (hclk),
    .rst_n        (rst_n),
    .start        (start),
    .out_of_range (out_of_range),
    .write        (write),
    .rd_wait      (rd_wait),
    .wr_wait      (wr_wait),
    .n_be         (smc_n_be),
    .smc_n_cs     (smc_n_cs),
    .smc_n_rd     (smc_n_rd),
    .smc_n_wr     (smc_n_wr),
    .smc_n_we     (smc_n_we),
    .smc_n_ext_oe (smc_n_ext_oe),
    .capture      (capture),
    .done         (done),
    .err_state    (err_state),
    .busy         (smc_busy)
  );

endmodule

`default_nettype wire

// ==== smc_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "smc_defines.svh"

// Access sequencer for the external memory bus
module smc_ctrl import smc_pkg::*; (
  input  wire logic                   hclk,
  input  wire logic                   rst_n,
  input  wire logic                   start,
  input  wire logic                   out_of_range,
  input  wire logic                   write,
  input  wire logic [`SMC_WAIT_W-1:0] rd_wait,
  input  wire logic [`SMC_WAIT_W-1:0] wr_wait,
  input  wire logic [3:0]             n_be,
  output logic                        smc_n_cs,
  output logic                        smc_n_rd,
  output logic                        smc_n_wr,
  output logic      [3:0]             smc_n_we,
  output logic                        smc_n_ext_oe,
  output logic                        capture,     // Latch read data now
  output logic                        done,        // Release hready
  output logic                        err_state,   // ERROR on hresp
  output logic                        busy
);

  smc_state_t             state;
  smc_state_t             nxt;
  logic [`SMC_WAIT_W-1:0] cnt;     // Remaining strobe cycles minus one
  logic                   last;    // Final strobe cycle
  logic                   cs_nxt;
  logic                   rd_nxt;
  logic                   wr_nxt;

  assign last = (cnt == '0);

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    nxt = state;
    case (state)
      // hready high here, a new access may start
      ST_IDLE, ST_DONE, ST_ERR2: begin
        if (start) begin
          nxt = out_of_range ? ST_ERR1 : ST_SETUP;
        end else begin
          nxt = ST_IDLE;
        end
      end
      ST_SETUP:  nxt = ST_STROBE;
      ST_STROBE: if (last) nxt = ST_DONE;  // Held wait+1 cycles
      ST_ERR1:   nxt = ST_ERR2;
      default:   nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= nxt;
    end
  end

  // --------------------------------------------------
  // Wait-state counter
  // --------------------------------------------------
  // Loaded in SETUP, write is valid from there on
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (state == ST_SETUP) begin
      cnt <= write ? wr_wait : rd_wait;
    end else if (state == ST_STROBE && !last) begin
      cnt <= cnt - 1'b1;
    end
  end

  // --------------------------------------------------
  // Memory strobes
  // --------------------------------------------------
  // Decoded from the next state so every pin comes
  // straight from a flop
  assign cs_nxt = (nxt == ST_SETUP) | (nxt == ST_STROBE);  // Never in ERR
  assign rd_nxt = (nxt == ST_STROBE) & ~write;
  assign wr_nxt = (nxt == ST_STROBE) & write;

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      smc_n_cs     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= 4'hf;
      smc_n_ext_oe <= 1'b1;
      busy         <= 1'b0;
    end else begin
      smc_n_cs     <= ~cs_nxt;
      smc_n_rd     <= ~rd_nxt;
      smc_n_wr     <= ~wr_nxt;
      smc_n_we     <= wr_nxt ? n_be : 4'hf;  // Enabled lanes only
      smc_n_ext_oe <= ~wr_nxt;               // Drive data while writing
      busy         <= (nxt != ST_IDLE);
    end
  end

  // --------------------------------------------------
  // Handshake to the AHB side
  // --------------------------------------------------
  assign capture   = (state == ST_STROBE) & last & ~write;
  assign done      = (state == ST_DONE) | (state == ST_ERR2);  // Second ERROR cycle too
  assign err_state = (state == ST_ERR1) | (state == ST_ERR2);

endmodule

`default_nettype wire

// ==== smc_lane_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "smc_defines.svh"

// Byte lanes, write data and external address
module smc_lane_gen import smc_pkg::*; (
  input  wire logic                   hclk,
  input  wire logic                   rst_n,
  input  wire logic                   start,      // Accept pulse, address phase
  input  wire logic [2:0]             size,       // Registered hsize
  input  wire logic [1:0]             addr_lo,    // Registered haddr[1:0]
  input  wire logic [`SMC_AW-3:0]     word_addr,
  input  wire logic [`SMC_DW-1:0]     hwdata,
  output logic      [`SMC_AW-1:0]     smc_addr,
  output logic      [`SMC_DW-1:0]     smc_data,
  output logic      [3:0]             n_be        // Active low
);

  logic       setup;  // First data-phase cycle
  logic [3:0] be;

  // --------------------------------------------------
  // Lane decode
  // --------------------------------------------------
  always_comb begin
    case (size)
      HSIZE_BYTE: be = 4'b0001 << addr_lo;              // One lane
      HSIZE_HALF: be = addr_lo[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
      default:    be = 4'b1111;                         // Word
    endcase
  end

  assign n_be = ~be;

  // Address stays put until the next accept
  assign smc_addr = {word_addr, 2'b00};

  // --------------------------------------------------
  // Write data capture
  // --------------------------------------------------
  // hwdata lags the address phase by one cycle
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      setup <= 1'b0;
    end else begin
      setup <= start;
    end
  end

  // Sampled in SETUP, driven through the strobe
  always_ff @(posedge hclk) begin
    if (setup) begin
      smc_data <= hwdata;
    end
  end

endmodule

`default_nettype wire

// ==== smc_ahb_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "smc_defines.svh"

// AHB-lite front end, single transfers only
module smc_ahb_slave import smc_pkg::*; (
  input  wire logic                   hclk,
  input  wire logic                   rst_n,
  input  wire logic                   hsel,
  input  wire logic [1:0]             htrans,
  input  wire logic                   hwrite,
  input  wire logic [2:0]             hsize,
  input  wire logic [`SMC_AW-1:0]     haddr,
  input  wire logic                   hready,       // Muxed ready from the fabric
  input  wire logic [`SMC_DW-1:0]     data_smc,     // External read data
  input  wire logic                   capture,      // Last read strobe cycle
  input  wire logic                   done,         // Access finished, release hready
  input  wire logic                   err_state,    // ERR1 or ERR2
  output logic                        start,
  output logic                        out_of_range,
  output logic                        write,
  output logic      [2:0]             size,
  output logic      [1:0]             addr_lo,
  output logic      [`SMC_AW-3:0]     word_addr,
  output logic      [`SMC_DW-1:0]     smc_hrdata,
  output logic                        smc_hready,
  output logic      [1:0]             smc_hresp
);

  // Byte size of the decoded window
  localparam logic [`SMC_AW-1:0] WINDOW_BYTES = `SMC_AW'(`SMC_MEM_WORDS * 4);

  htrans_t trans;
  hresp_t  resp;
  logic    pending;  // Data phase still open

  // --------------------------------------------------
  // Address phase qualify and decode
  // --------------------------------------------------
  assign trans = htrans_t'(htrans);

  // SEQ handled like NONSEQ, no bursts
  assign start = hsel & hready &
                 ((trans == HTRANS_NONSEQ) | (trans == HTRANS_SEQ));

  // Only looked at together with start
  assign out_of_range = (haddr >= WINDOW_BYTES);

  // Address phase held for the whole access
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      write <= 1'b0;
    end else if (start) begin
      write <= hwrite;
    end
  end

  always_ff @(posedge hclk) begin
    if (start) begin
      size      <= hsize;
      addr_lo   <= haddr[1:0];
      word_addr <= haddr[`SMC_AW-1:2];  // Word aligned part
    end
  end

  // --------------------------------------------------
  // Data phase
  // --------------------------------------------------
  // Set on accept, cleared by the done pulse; an accept
  // in the done cycle keeps it set
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (start) begin
      pending <= 1'b1;
    end else if (done) begin
      pending <= 1'b0;
    end
  end

  // Read word sampled at the end of the strobe
  always_ff @(posedge hclk) begin
    if (capture) begin
      smc_hrdata <= data_smc;
    end
  end

  assign smc_hready = ~pending | done;  // High when idle too

  // ERROR held across both error cycles
  assign resp      = err_state ? HRESP_ERROR : HRESP_OKAY;
  assign smc_hresp = resp;

endmodule

`default_nettype wire

// ==== smc_apb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "smc_defines.svh"

// Wait-state configuration, APB on hclk
module smc_apb_regs import smc_pkg::*; (
  input  wire logic                   hclk,
  input  wire logic                   rst_n,
  input  wire logic                   psel,
  input  wire logic                   penable,
  input  wire logic                   pwrite,
  input  wire logic [4:0]             paddr,
  input  wire logic [31:0]            pwdata,
  input  wire logic                   busy,     // From the controller
  output logic      [31:0]            prdata,
  output logic      [`SMC_WAIT_W-1:0] rd_wait,
  output logic      [`SMC_WAIT_W-1:0] wr_wait
);

  logic apb_wr;  // Access phase of a write

  assign apb_wr = psel & penable & pwrite;

  // --------------------------------------------------
  // Register write
  // --------------------------------------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      rd_wait <= `SMC_WAIT_W'(`SMC_RD_WAIT_RST);
      wr_wait <= `SMC_WAIT_W'(`SMC_WR_WAIT_RST);
    end else if (apb_wr) begin
      case (paddr)
        REG_RD_WAIT: rd_wait <= pwdata[`SMC_WAIT_W-1:0];
        REG_WR_WAIT: wr_wait <= pwdata[`SMC_WAIT_W-1:0];
        default: ;  // STATUS is read only
      endcase
    end
  end

  // --------------------------------------------------
  // Read-back mux
  // --------------------------------------------------
  // Not gated by psel, the bridge only samples it
  // in the access phase
  always_comb begin
    prdata = '0;
    case (paddr)
      REG_RD_WAIT: prdata[`SMC_WAIT_W-1:0] = rd_wait;
      REG_WR_WAIT: prdata[`SMC_WAIT_W-1:0] = wr_wait;
      REG_STATUS:  prdata[0]               = busy;   // Access in flight
      default:     prdata                  = '0;     // Unmapped offset
    endcase
  end

endmodule

`default_nettype wire

// ==== smc_pkg.sv ====
`default_nettype none

package smc_pkg;

  // Controller sequencing states
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,  // No access in flight
    ST_SETUP  = 3'd1,  // Chip select and address out
    ST_STROBE = 3'd2,  // Read or write strobe low
    ST_DONE   = 3'd3,  // Ready back to the master
    ST_ERR1   = 3'd4,  // First ERROR cycle, hready low
    ST_ERR2   = 3'd5   // Second ERROR cycle, hready high
  } smc_state_t;

  // AHB transfer type
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  // AHB response, no RETRY or SPLIT on AHB-lite
  typedef enum logic [1:0] {
    HRESP_OKAY  = 2'b00,
    HRESP_ERROR = 2'b01
  } hresp_t;

  // AHB transfer sizes used by the lane decode
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;

  // APB register map
  localparam logic [4:0] REG_RD_WAIT = 5'h00;
  localparam logic [4:0] REG_WR_WAIT = 5'h04;
  localparam logic [4:0] REG_STATUS  = 5'h08;

endpackage

`default_nettype wire

// ==== smc_defines.svh ====
`ifndef SMC_DEFINES_SVH
`define SMC_DEFINES_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define SMC_AW 32            // External address width
`define SMC_DW 32            // Data width, AHB and memory side

// Decoded window in words
// Byte addresses at or above 4x this get ERROR
`define SMC_MEM_WORDS 256

// --------------------------------------------------
// Wait states
// --------------------------------------------------
`define SMC_WAIT_W 4         // Wait field width

// Reset values of the programmable counts
`define SMC_RD_WAIT_RST 2
`define SMC_WR_WAIT_RST 1

`endif
